/* rtl/savestate_defines.svh */
`ifndef SAVESTATE_DEFINES_SVH
`define SAVESTATE_DEFINES_SVH

// Host bus geometry
`define SS_ADDR_W 8
`define SS_DATA_W 32

// Savestate register map
`define SS_ADDR_CORE0 8'h00
`define SS_ADDR_CORE1 8'h01
`define SS_ADDR_CLOCK 8'h02
`define SS_ADDR_PROG  8'h04

// CPU RAM window on the bus, one word per eight nibbles
`define SS_RAM_BASE  8'h10
`define SS_RAM_WORDS 8'd80

// CPU RAM geometry
`define RAM_NIBBLES      640
`define NIBBLES_PER_WORD 8

// Power-on values of the CPU registers
`define PC_RESET 13'h0100
`define NP_RESET 5'h01

// Prog timer starts from the top of its range
`define PROG_DOWN_RESET 8'hFF

`endif

/* rtl/savestate_pkg.sv */
`include "savestate_defines.svh"

package savestate_pkg;

    // Host savestate bus
    typedef logic [`SS_ADDR_W-1:0] ss_addr_t;
    typedef logic [`SS_DATA_W-1:0] ss_data_t;

    // One RAM cell, also the width of a and b
    typedef logic [3:0] nibble_t;

    // Program counter, bank bit included
    typedef logic [12:0] pc_t;

    // New page register
    typedef logic [4:0] np_t;

    // x and y index registers
    typedef logic [11:0] index_t;

    // Stack pointer, also reused for the prog timer reload value
    typedef logic [7:0] sp_t;

    // Nibble address into the CPU RAM
    typedef logic [$clog2(`RAM_NIBBLES)-1:0] ram_addr_t;

    // RAM bridge FSM
    typedef enum logic [1:0] {
        br_idle,
        br_write,
        br_read
    } bridge_state_t;

endpackage

/* rtl/core_regs.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module core_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  savestate_pkg::ss_data_t ss_bus_in,
    input  logic                    wr_word0,
    input  logic                    wr_word1,
    output savestate_pkg::ss_data_t word0,
    output savestate_pkg::ss_data_t word1
);

    savestate_pkg::pc_t     pc;
    savestate_pkg::np_t     np;
    savestate_pkg::nibble_t a;
    savestate_pkg::nibble_t b;
    savestate_pkg::index_t  x;
    savestate_pkg::index_t  y;
    savestate_pkg::sp_t     sp;
    logic                   interrupt;
    logic                   decimal;
    logic                   zero;
    logic                   carry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= `PC_RESET;
            np        <= `NP_RESET;
            a         <= '0;
            b         <= '0;
            x         <= '0;
            y         <= '0;
            sp        <= '0;
            interrupt <= 1'b0;
            decimal   <= 1'b0;
            zero      <= 1'b0;
            carry     <= 1'b0;
        end else begin
            // Word 0, top two bits unused
            if (wr_word0) begin
                np        <= ss_bus_in[29:25];
                pc        <= ss_bus_in[24:12];
                a         <= ss_bus_in[11:8];
                b         <= ss_bus_in[7:4];
                interrupt <= ss_bus_in[3];
                decimal   <= ss_bus_in[2];
                zero      <= ss_bus_in[1];
                carry     <= ss_bus_in[0];
            end
            // Word 1 holds x, y and sp
            if (wr_word1) begin
                x  <= ss_bus_in[31:20];
                y  <= ss_bus_in[19:8];
                sp <= ss_bus_in[7:0];
            end
        end
    end

    assign word0 = {2'b00, np, pc, a, b, interrupt, decimal, zero, carry};
    assign word1 = {x, y, sp};

endmodule

/* rtl/clock_timer.sv */
`timescale 1ns/1ps

module clock_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  savestate_pkg::ss_data_t ss_bus_in,
    input  logic                    wr,
    output savestate_pkg::ss_data_t state_word,
    output logic                    tick
);

    // 128-step prescaler ahead of the 256-step counter
    logic [6:0] divider;
    logic [7:0] counter_256;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divider     <= '0;
            counter_256 <= '0;
            tick        <= 1'b0;
        end else if (wr) begin
            tick        <= ss_bus_in[15];
            divider     <= ss_bus_in[14:8];
            counter_256 <= ss_bus_in[7:0];
        end else begin
            divider <= divider + 7'd1;
            // Divider wraps on this edge
            if (&divider) begin
                counter_256 <= counter_256 + 8'd1;
                tick        <= 1'b1;
            end else begin
                tick <= 1'b0;
            end
        end
    end

    assign state_word = {16'h0000, tick, divider, counter_256};

endmodule

/* rtl/prog_timer.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module prog_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  savestate_pkg::ss_data_t ss_bus_in,
    input  logic                    wr,
    input  logic                    enable,
    input  savestate_pkg::sp_t      reload,
    output savestate_pkg::ss_data_t state_word,
    output logic                    factor
);

    // Prescaler, 64 steps and then a toggle bit
    logic [5:0]         counter_8khz;
    logic               divider_8khz;
    savestate_pkg::sp_t downcounter;
    // Sticky underflow flag
    logic               factor_flag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter_8khz <= '0;
            divider_8khz <= 1'b0;
            downcounter  <= `PROG_DOWN_RESET;
            factor_flag  <= 1'b0;
        end else if (wr) begin
            factor_flag  <= ss_bus_in[15];
            downcounter  <= ss_bus_in[14:7];
            divider_8khz <= ss_bus_in[6];
            counter_8khz <= ss_bus_in[5:0];
        end else if (enable) begin
            counter_8khz <= counter_8khz + 6'd1;
            if (&counter_8khz) begin
                divider_8khz <= ~divider_8khz;
                // Step on the 1 to 0 toggle
                if (divider_8khz) begin
                    if (downcounter == '0) begin
                        downcounter <= reload;
                        factor_flag <= 1'b1;
                    end else begin
                        downcounter <= downcounter - 8'd1;
                    end
                end
            end
        end
    end

    assign state_word = {16'h0000, factor_flag, downcounter, divider_8khz, counter_8khz};
    assign factor     = factor_flag;

endmodule

/* rtl/cpu_ram.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module cpu_ram (
    input  logic                      clk,
    input  savestate_pkg::ram_addr_t  addr,
    input  logic                      we,
    input  savestate_pkg::nibble_t    wdata,
    output savestate_pkg::nibble_t    rdata
);

    // One nibble per CPU RAM cell
    savestate_pkg::nibble_t mem [`RAM_NIBBLES];

    // Single port, read data registered one cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* rtl/ram_bridge.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module ram_bridge (
    input  logic                      clk,
    input  logic                      rst_n,
    input  savestate_pkg::ss_addr_t   ss_bus_addr,
    input  savestate_pkg::ss_data_t   ss_bus_in,
    input  logic                      wr,
    input  logic                      sel,
    input  savestate_pkg::nibble_t    ram_rdata,
    output savestate_pkg::ram_addr_t  ram_addr,
    output logic                      ram_we,
    output savestate_pkg::nibble_t    ram_wdata,
    output savestate_pkg::ss_data_t   word
);

    localparam int WORD_W = $clog2(`SS_RAM_WORDS);
    localparam int NIB_W  = $clog2(`NIBBLES_PER_WORD);

    savestate_pkg::bridge_state_t state;
    logic [NIB_W-1:0]             nib_idx;
    logic [WORD_W-1:0]            word_idx;
    logic [WORD_W-1:0]            bus_word_idx;
    savestate_pkg::ss_addr_t      addr_offset;
    savestate_pkg::ss_addr_t      last_addr;
    savestate_pkg::ss_data_t      shift;
    logic                         addr_changed;

    assign addr_offset  = ss_bus_addr - `SS_RAM_BASE;
    assign bus_word_idx = addr_offset[WORD_W-1:0];
    assign addr_changed = sel && (ss_bus_addr != last_addr);

    // While idle, nibble 0 of the live address sits on the RAM so that
    // a read sweep has its first data on the edge that starts it
    assign ram_addr  = (state == savestate_pkg::br_idle) ? {bus_word_idx, {NIB_W{1'b0}}}
                                                         : {word_idx, nib_idx};
    assign ram_we    = (state == savestate_pkg::br_write);
    assign ram_wdata = shift[3:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= savestate_pkg::br_idle;
            nib_idx   <= '0;
            last_addr <= '0;
            word      <= '0;
        end else begin
            case (state)
                savestate_pkg::br_idle: begin
                    last_addr <= ss_bus_addr;
                    if (wr) begin
                        state   <= savestate_pkg::br_write;
                        nib_idx <= '0;
                    end else if (addr_changed) begin
                        state   <= savestate_pkg::br_read;
                        nib_idx <= NIB_W'(1);
                    end
                end
                savestate_pkg::br_write: begin
                    nib_idx <= nib_idx + 1'b1;
                    if (nib_idx == NIB_W'(`NIBBLES_PER_WORD - 1)) begin
                        state <= savestate_pkg::br_idle;
                    end
                end
                savestate_pkg::br_read: begin
                    nib_idx <= nib_idx + 1'b1;
                    // Index has wrapped, last nibble is on ram_rdata
                    if (nib_idx == '0) begin
                        word  <= {ram_rdata, shift[31:4]};
                        state <= savestate_pkg::br_idle;
                    end
                end
                default: state <= savestate_pkg::br_idle;
            endcase
        end
    end

    // Shift register serves both directions, low nibble first
    always_ff @(posedge clk) begin
        if (state == savestate_pkg::br_idle) begin
            word_idx <= bus_word_idx;
            shift    <= ss_bus_in;
        end else if (state == savestate_pkg::br_write) begin
            shift <= {4'h0, shift[31:4]};
        end else begin
            shift <= {ram_rdata, shift[31:4]};
        end
    end

endmodule

/* rtl/savestate_top.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module savestate_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  savestate_pkg::ss_addr_t ss_bus_addr,
    input  savestate_pkg::ss_data_t ss_bus_in,
    input  logic                    ss_bus_wren,
    input  logic                    prog_timer_enable,
    input  savestate_pkg::sp_t      prog_timer_reload,
    output savestate_pkg::ss_data_t ss_bus_out,
    output logic                    timer_256_tick,
    output logic                    prog_timer_factor
);

    savestate_pkg::ss_data_t   core_word0;
    savestate_pkg::ss_data_t   core_word1;
    savestate_pkg::ss_data_t   clock_word;
    savestate_pkg::ss_data_t   prog_word;
    savestate_pkg::ss_data_t   bridge_word;
    savestate_pkg::ss_data_t   read_word;
    savestate_pkg::ram_addr_t  ram_addr;
    savestate_pkg::nibble_t    ram_wdata;
    savestate_pkg::nibble_t    ram_rdata;
    logic                      ram_we;
    logic                      ram_sel;

    // RAM window is 0x10 up to 0x5F
    assign ram_sel = (ss_bus_addr >= `SS_RAM_BASE) &&
                     (ss_bus_addr < `SS_RAM_BASE + `SS_RAM_WORDS);

    core_regs core_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ss_bus_in (ss_bus_in),
        .wr_word0  (ss_bus_wren && (ss_bus_addr == `SS_ADDR_CORE0)),
        .wr_word1  (ss_bus_wren && (ss_bus_addr == `SS_ADDR_CORE1)),
        .word0     (core_word0),
        .word1     (core_word1)
    );

    clock_timer clock_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ss_bus_in  (ss_bus_in),
        .wr         (ss_bus_wren && (ss_bus_addr == `SS_ADDR_CLOCK)),
        .state_word (clock_word),
        .tick       (timer_256_tick)
    );

    prog_timer prog_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ss_bus_in  (ss_bus_in),
        .wr         (ss_bus_wren && (ss_bus_addr == `SS_ADDR_PROG)),
        .enable     (prog_timer_enable),
        .reload     (prog_timer_reload),
        .state_word (prog_word),
        .factor     (prog_timer_factor)
    );

    ram_bridge ram_bridge_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ss_bus_addr (ss_bus_addr),
        .ss_bus_in   (ss_bus_in),
        .wr          (ss_bus_wren && ram_sel),
        .sel         (ram_sel),
        .ram_rdata   (ram_rdata),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .ram_wdata   (ram_wdata),
        .word        (bridge_word)
    );

    cpu_ram cpu_ram_i (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // Unmapped addresses read as zero
    always_comb begin
        case (ss_bus_addr)
            `SS_ADDR_CORE0: read_word = core_word0;
            `SS_ADDR_CORE1: read_word = core_word1;
            `SS_ADDR_CLOCK: read_word = clock_word;
            `SS_ADDR_PROG:  read_word = prog_word;
            default:        read_word = ram_sel ? bridge_word : '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ss_bus_out <= '0;
        end else begin
            ss_bus_out <= read_word;
        end
    end

endmodule

/* test/savestate_tb.sv */
`timescale 1ns/1ps
`include "savestate_defines.svh"

module savestate_tb;

    localparam int CLK_HALF        = 20;
    localparam int RAM_WORDS       = `SS_RAM_WORDS;
    localparam int CLOCK_WAIT      = 100;
    localparam int PROG_WAIT       = 135;
    localparam int WATCHDOG_CYCLES = RAM_WORDS * 20 + 400;

    logic                    clk = 1'b0;
    logic                    rst_n;
    savestate_pkg::ss_addr_t ss_bus_addr;
    savestate_pkg::ss_data_t ss_bus_in;
    logic                    ss_bus_wren;
    logic                    prog_timer_enable;
    savestate_pkg::sp_t      prog_timer_reload;
    savestate_pkg::ss_data_t ss_bus_out;
    logic                    timer_256_tick;
    logic                    prog_timer_factor;

    // Check request from the stimulus to the comparing process
    event                    check_ev;
    savestate_pkg::ss_data_t exp_word;
    logic                    exp_tick;
    logic                    exp_factor;
    logic                    chk_word;
    logic                    chk_tick;
    logic                    chk_factor;
    string                   chk_msg;

    int                      errors = 0;
    int                      checks = 0;
    integer                  seed = 49167;
    savestate_pkg::ss_data_t ram_copy [RAM_WORDS];
    savestate_pkg::ss_data_t wr_word;
    savestate_pkg::ss_addr_t addr;
    int                      i;

    savestate_top savestate_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .ss_bus_addr       (ss_bus_addr),
        .ss_bus_in         (ss_bus_in),
        .ss_bus_wren       (ss_bus_wren),
        .prog_timer_enable (prog_timer_enable),
        .prog_timer_reload (prog_timer_reload),
        .ss_bus_out        (ss_bus_out),
        .timer_256_tick    (timer_256_tick),
        .prog_timer_factor (prog_timer_factor)
    );

    always #CLK_HALF clk = ~clk;

    // Timer model in which prog selects the prog timer layout over the clock timer
    function automatic savestate_pkg::ss_data_t expect_timer(
        input logic prog, input savestate_pkg::ss_data_t written, input int steps,
        input logic enable, input savestate_pkg::sp_t reload);
        logic [6:0] div7;
        logic [7:0] cnt8;
        logic       tick;
        logic [5:0] cnt6;
        logic       div1;
        logic [7:0] down;
        logic       flag;
        int         n;
        tick = written[15];
        div7 = written[14:8];
        cnt8 = written[7:0];
        flag = written[15];
        down = written[14:7];
        div1 = written[6];
        cnt6 = written[5:0];
        for (n = 0; n < steps; n++) begin
            if (!prog) begin
                tick = (div7 == 7'd127);
                if (tick) cnt8 = cnt8 + 8'd1;
                div7 = div7 + 7'd1;
            end else if (enable) begin
                // Down-counter steps when the prescaler bit falls
                if (cnt6 == 6'd63) begin
                    if (div1) begin
                        if (down == 8'd0) begin
                            down = reload;
                            flag = 1'b1;
                        end else begin
                            down = down - 8'd1;
                        end
                    end
                    div1 = ~div1;
                end
                cnt6 = cnt6 + 6'd1;
            end
        end
        if (prog) return {16'h0000, flag, down, div1, cnt6};
        return {16'h0000, tick, div7, cnt8};
    endfunction

    task automatic request_check(input savestate_pkg::ss_data_t word, input logic use_word,
                                 input logic tick, input logic use_tick,
                                 input logic factor, input logic use_factor,
                                 input string msg);
        exp_word   = word;
        chk_word   = use_word;
        exp_tick   = tick;
        chk_tick   = use_tick;
        exp_factor = factor;
        chk_factor = use_factor;
        chk_msg    = msg;
        -> check_ev;
    endtask

    // One-cycle write strobe that returns on the falling edge after the write edge
    task automatic bus_write(input savestate_pkg::ss_addr_t a, input savestate_pkg::ss_data_t d);
        ss_bus_addr = a;
        ss_bus_in   = d;
        ss_bus_wren = 1'b1;
        @(negedge clk);
        ss_bus_wren = 1'b0;
    endtask

    task automatic read_check(input savestate_pkg::ss_addr_t a, input savestate_pkg::ss_data_t exp,
                              input int wait_cycles, input string msg);
        ss_bus_addr = a;
        repeat (wait_cycles) @(negedge clk);
        request_check(exp, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, msg);
    endtask

    always begin
        @(check_ev);
        checks = checks + 1;
        if (chk_word && ss_bus_out !== exp_word) begin
            $display("Error at %0d ns: %s read %h, expected %h",
                     $time, chk_msg, ss_bus_out, exp_word);
            errors = errors + 1;
        end
        if (chk_tick && timer_256_tick !== exp_tick) begin
            $display("Error at %0d ns: %s timer_256_tick is %b, expected %b",
                     $time, chk_msg, timer_256_tick, exp_tick);
            errors = errors + 1;
        end
        if (chk_factor && prog_timer_factor !== exp_factor) begin
            $display("Error at %0d ns: %s prog_timer_factor is %b, expected %b",
                     $time, chk_msg, prog_timer_factor, exp_factor);
            errors = errors + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("Timeout: the test sequence did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("Errors: %0d, checks: %0d", errors, checks);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n             = 1'b0;
        ss_bus_addr       = `SS_ADDR_CORE0;
        ss_bus_in         = '0;
        ss_bus_wren       = 1'b0;
        prog_timer_enable = 1'b0;
        prog_timer_reload = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Power-on values with np 0x01 and pc 0x100
        ss_bus_addr = `SS_ADDR_CORE0;
        @(negedge clk);
        request_check({2'b00, 5'h01, 13'h0100, 12'h000}, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1,
                      "reset word 0");
        read_check(`SS_ADDR_CORE1, 32'h0, 1, "reset word 1");
        read_check(`SS_ADDR_PROG, {16'h0000, 1'b0, 8'hFF, 1'b0, 6'd0}, 1, "reset prog timer");

        wr_word = $random(seed) & 32'h3FFF_FFFF;
        bus_write(`SS_ADDR_CORE0, wr_word);
        read_check(`SS_ADDR_CORE0, wr_word, 1, "core word 0");
        wr_word = $random(seed);
        bus_write(`SS_ADDR_CORE1, wr_word);
        read_check(`SS_ADDR_CORE1, wr_word, 1, "core word 1");

        wr_word = $random(seed);
        bus_write(`SS_ADDR_CLOCK, wr_word);
        repeat (CLOCK_WAIT) @(negedge clk);
        request_check(expect_timer(1'b0, wr_word, CLOCK_WAIT - 1, 1'b0, 8'h00),
                      1'b1, 1'b0, 1'b0, 1'b0, 1'b0, "clock timer");
        // Divider at 127 wraps on the next edge
        bus_write(`SS_ADDR_CLOCK, {16'h0000, 1'b0, 7'd127, 8'h5A});
        request_check('0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "tick after write");
        @(negedge clk);
        request_check('0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, "tick on wrap");
        @(negedge clk);
        request_check('0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, "tick one cycle later");

        wr_word = $random(seed);
        bus_write(`SS_ADDR_PROG, wr_word);
        read_check(`SS_ADDR_PROG, expect_timer(1'b1, wr_word, 2, 1'b0, 8'h00), 2,
                   "prog timer disabled");
        prog_timer_reload = 8'($random(seed));
        prog_timer_enable = 1'b1;
        wr_word = {16'h0000, 1'b0, 8'h00, 1'b1, 6'd63};
        bus_write(`SS_ADDR_PROG, wr_word);
        @(negedge clk);
        request_check(wr_word, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, "prog timer underflow");
        repeat (PROG_WAIT) @(negedge clk);
        request_check(expect_timer(1'b1, wr_word, PROG_WAIT, 1'b1, prog_timer_reload),
                      1'b1, 1'b0, 1'b0, 1'b1, 1'b1, "prog timer running");
        prog_timer_enable = 1'b0;

        // Fill the whole RAM window and read it back
        for (i = 0; i < RAM_WORDS; i++) begin
            ram_copy[i] = $random(seed);
            addr = `SS_RAM_BASE + i[7:0];
            bus_write(addr, ram_copy[i]);
            repeat (9) @(negedge clk);
        end
        for (i = 0; i < RAM_WORDS; i++) begin
            addr = `SS_RAM_BASE + i[7:0];
            read_check(addr, ram_copy[i], 10, $sformatf("RAM word %0d", i));
        end

        read_check(8'h03, 32'h0, 1, "unmapped 0x03");
        for (i = 8'h05; i <= 8'h0F; i++) begin
            read_check(i[7:0], 32'h0, 1, $sformatf("unmapped 0x%02h", i));
        end
        for (i = 8'h60; i <= 8'h67; i++) begin
            read_check(i[7:0], 32'h0, 1, $sformatf("unmapped 0x%02h", i));
        end

        @(negedge clk);
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/savestate_pkg.sv
rtl/core_regs.sv
rtl/clock_timer.sv
rtl/prog_timer.sv
rtl/cpu_ram.sv
rtl/ram_bridge.sv
rtl/savestate_top.sv
test/savestate_tb.sv

/* Bender.yml */
package:
  name: savestate

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/savestate_pkg.sv
      - rtl/core_regs.sv
      - rtl/clock_timer.sv
      - rtl/prog_timer.sv
      - rtl/cpu_ram.sv
      - rtl/ram_bridge.sv
      - rtl/savestate_top.sv
  - target: test
    files:
      - test/savestate_tb.sv
